// ==== design/controlPkg.sv ====
`default_nettype none

package controlPkg;

    // Numbering follows the instruction set encoding
    typedef enum logic [5:0] {
        opAnd   = 6'd0,
        opAdd   = 6'd1,
        opSub   = 6'd2,
        opAndi  = 6'd3,
        opAddi  = 6'd4,
        opLw    = 6'd5,
        opLwpoi = 6'd6,
        opSw    = 6'd7,
        opBgt   = 6'd8,
        opBlt   = 6'd9,
        opBeq   = 6'd10,
        opBne   = 6'd11,
        opJmp   = 6'd12,
        opCall  = 6'd13,
        opRet   = 6'd14,
        opPush  = 6'd15,
        opPop   = 6'd16
    } opcodeT;

    typedef enum logic [2:0] {
        fetchPhase     = 3'd0,
        capturePhase   = 3'd1,
        decodePhase    = 3'd2,
        readPhase      = 3'd3,
        executePhase   = 3'd4,
        memoryPhase    = 3'd5,
        writePrepPhase = 3'd6,
        writebackPhase = 3'd7
    } phaseT;

    // JMP rides with the conditional branches
    typedef enum logic [2:0] {
        aluClass    = 3'd0,
        loadClass   = 3'd1,
        storeClass  = 3'd2,
        branchClass = 3'd3,
        callClass   = 3'd4,
        pushClass   = 3'd5,
        popClass    = 3'd6,
        retClass    = 3'd7
    } instrClassT;

    typedef enum logic [1:0] {
        pcJump   = 2'd0,
        pcNext   = 2'd2,
        pcBranch = 2'd3
    } pcSourceT;

    typedef enum logic [1:0] {
        srcRegister   = 2'd0,
        srcJumpOffset = 2'd1,
        srcImmediate  = 2'd2
    } aluSrcTwoT;

    typedef struct packed {
        logic      memRead;
        logic      memWrite;
        logic      memToRf;
        logic      regTwoSrc;
        logic      extSrc;
        logic      aluSrcOne;
        aluSrcTwoT aluSrcTwo;
        pcSourceT  pcSource;
        logic [3:0] aluOp;
    } ctrlWordT;

    typedef struct packed {
        logic zero;
        logic greater;
        logic less;
    } aluFlagsT;

endpackage

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::phaseT      phase,
    input  controlPkg::opcodeT     opcode,
    input  logic [1:0]             modeBits,
    output controlPkg::opcodeT     heldOp,
    output controlPkg::instrClassT instrClass,
    output controlPkg::ctrlWordT   ctrl,
    output logic                   modeFlag
);
    import controlPkg::*;

    opcodeT opReg;

    always_ff @(posedge clk) begin
        if (phase == capturePhase) begin
            opReg <= opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            modeFlag <= 1'b0;
        end else if (phase == capturePhase) begin
            modeFlag <= (opcode == opLwpoi) && (modeBits == 2'b01);
        end
    end

    // New opcode shows through during capture so the sequencer can pick
    // the first phase and the stack unit can fire RET pop right away
    assign heldOp = (phase == capturePhase) ? opcode : opReg;

    always_comb begin
        case (heldOp)
            opLw, opLwpoi:                    instrClass = loadClass;
            opSw:                             instrClass = storeClass;
            opBgt, opBlt, opBeq, opBne, opJmp: instrClass = branchClass;
            opCall:                           instrClass = callClass;
            opRet:                            instrClass = retClass;
            opPush:                           instrClass = pushClass;
            opPop:                            instrClass = popClass;
            default:                          instrClass = aluClass;
        endcase
    end

    always_comb begin
        ctrl.aluOp     = heldOp[3:0];
        ctrl.memRead   = (heldOp == opLw) || (heldOp == opLwpoi);
        ctrl.memWrite  = (heldOp == opSw);
        ctrl.memToRf   = heldOp inside {opAnd, opAdd, opSub, opAndi, opAddi};
        ctrl.regTwoSrc = heldOp inside {opSw, opBgt, opBlt, opBeq, opBne};
        ctrl.extSrc    = (heldOp == opAndi);
        ctrl.aluSrcOne = !((heldOp == opJmp) || (heldOp == opCall));

        case (heldOp)
            opAndi, opAddi, opLw, opLwpoi, opSw: ctrl.aluSrcTwo = srcImmediate;
            opJmp, opCall:                       ctrl.aluSrcTwo = srcJumpOffset;
            default:                             ctrl.aluSrcTwo = srcRegister;
        endcase

        case (heldOp)
            opBgt, opBlt, opBeq, opBne: ctrl.pcSource = pcBranch;
            opJmp, opCall, opPop:       ctrl.pcSource = pcJump;
            default:                    ctrl.pcSource = pcNext;
        endcase
    end

    // Instruction memory must only hand over defined opcodes
    assert property (@(posedge clk) disable iff (reset)
        phase == capturePhase |-> opcode inside {[opAnd:opPop]});

endmodule

`default_nettype wire

// ==== design/phaseSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    output controlPkg::phaseT      phase,
    output logic                   irWrite,
    output logic                   pcEnable,
    output logic                   rfWrite,
    output logic                   regLatch
);
    import controlPkg::*;

    phaseT nextPhase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= fetchPhase;
        end else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        nextPhase = fetchPhase;
        case (phase)
            fetchPhase: begin
                nextPhase = capturePhase;
            end
            capturePhase: begin
                // RET goes straight to the stack access
                nextPhase = (instrClass == retClass) ? memoryPhase : decodePhase;
            end
            decodePhase: begin
                if (instrClass == pushClass || instrClass == popClass) begin
                    nextPhase = memoryPhase;
                end else begin
                    nextPhase = readPhase;
                end
            end
            readPhase: begin
                nextPhase = executePhase;
            end
            executePhase: begin
                case (instrClass)
                    aluClass:                        nextPhase = writePrepPhase;
                    loadClass, storeClass, callClass: nextPhase = memoryPhase;
                    default:                         nextPhase = fetchPhase;
                endcase
            end
            memoryPhase: begin
                if (instrClass == loadClass || instrClass == popClass) begin
                    nextPhase = writePrepPhase;
                end else begin
                    nextPhase = fetchPhase;
                end
            end
            writePrepPhase: begin
                nextPhase = writebackPhase;
            end
            default: begin
                nextPhase = fetchPhase;
            end
        endcase
    end

    assign irWrite  = (phase == fetchPhase);
    assign pcEnable = (phase == fetchPhase);
    assign rfWrite  = (phase == writePrepPhase) || (phase == writebackPhase);
    assign regLatch = (phase == decodePhase) || (phase == readPhase);

    assert property (@(posedge clk) disable iff (reset)
        phase == memoryPhase |=> phase != memoryPhase);

endmodule

`default_nettype wire

// ==== design/branchResolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  logic                 clk,
    input  logic                 reset,
    input  controlPkg::phaseT    phase,
    input  controlPkg::opcodeT   heldOp,
    input  controlPkg::aluFlagsT flags,
    output logic                 branchTaken
);
    import controlPkg::*;

    logic takeNow;

    // Only the four conditional branches can be taken
    always_comb begin
        case (heldOp)
            opBgt:   takeNow = flags.greater;
            opBlt:   takeNow = flags.less;
            opBeq:   takeNow = flags.zero;
            opBne:   takeNow = !flags.zero;
            default: takeNow = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            branchTaken <= 1'b0;
        end else if (phase == executePhase) begin
            branchTaken <= takeNow;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && $changed(branchTaken) |-> $past(phase) == executePhase);

endmodule

`default_nettype wire

// ==== design/stackControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stackControl (
    input  logic               clk,
    input  logic               reset,
    input  controlPkg::phaseT  phase,
    input  controlPkg::opcodeT heldOp,
    output logic               push,
    output logic               pop,
    output logic               callFlag,
    output logic               stackAddress
);
    import controlPkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
            pop  <= 1'b0;
        end else begin
            // CALL pushes the return address once the target is computed
            push <= ((phase == decodePhase) && (heldOp == opPush))
                 || ((phase == executePhase) && (heldOp == opCall));
            pop  <= ((phase == capturePhase) && (heldOp == opRet))
                 || ((phase == decodePhase) && (heldOp == opPop));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            callFlag     <= 1'b0;
            stackAddress <= 1'b0;
        end else if (phase == capturePhase) begin
            callFlag     <= (heldOp == opCall);
            stackAddress <= 1'b0;
        end else if ((phase == memoryPhase) && (heldOp == opRet)) begin
            // PC takes the popped address on the way back to fetch
            stackAddress <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(push && pop));

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  controlPkg::opcodeT   opcode,
    input  logic [1:0]           modeBits,
    input  controlPkg::aluFlagsT flags,
    output logic                 irWrite,
    output logic                 pcEnable,
    output logic                 rfWrite,
    output logic                 regLatch,
    output controlPkg::ctrlWordT ctrl,
    output logic                 branchTaken,
    output logic                 push,
    output logic                 pop,
    output logic                 callFlag,
    output logic                 stackAddress,
    output logic                 modeFlag
);
    import controlPkg::*;

    phaseT      phase;
    opcodeT     heldOp;
    instrClassT instrClass;

    instrDecoder decoder (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .opcode    (opcode),
        .modeBits  (modeBits),
        .heldOp    (heldOp),
        .instrClass(instrClass),
        .ctrl      (ctrl),
        .modeFlag  (modeFlag)
    );

    phaseSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .instrClass(instrClass),
        .phase     (phase),
        .irWrite   (irWrite),
        .pcEnable  (pcEnable),
        .rfWrite   (rfWrite),
        .regLatch  (regLatch)
    );

    branchResolver branchUnit (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .heldOp     (heldOp),
        .flags      (flags),
        .branchTaken(branchTaken)
    );

    stackControl stackUnit (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .heldOp      (heldOp),
        .push        (push),
        .pop         (pop),
        .callFlag    (callFlag),
        .stackAddress(stackAddress)
    );

endmodule

`default_nettype wire

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import controlPkg::*;

    // Expected timing, strobe counts and decode fields per opcode
    typedef struct packed {
        logic [3:0] cycles;
        logic [1:0] rfCycles;
        logic       pushes;
        logic       pops;
        logic       memRead;
        aluSrcTwoT  aluSrcTwo;
        pcSourceT   pcSource;
    } expectT;

    localparam int numInstr = 300;

    logic        clk;
    logic        reset;
    opcodeT      opcode;
    logic [1:0]  modeBits;
    aluFlagsT    flags;
    logic        irWrite;
    logic        pcEnable;
    logic        rfWrite;
    logic        regLatch;
    ctrlWordT    ctrl;
    logic        branchTaken;
    logic        push;
    logic        pop;
    logic        callFlag;
    logic        stackAddress;
    logic        modeFlag;

    // Copy of the instruction in flight
    opcodeT      issuedOp;
    logic [1:0]  issuedMode;
    aluFlagsT    issuedFlags;
    int          issuedCount;

    logic [31:0] rngState;
    int          sinceFetch;
    int          rfCount;
    int          pushCount;
    int          popCount;
    int          errorCount;
    int          timeoutCount;

    expectT      want;
    logic        wantTaken;
    logic        wantMode;
    logic        wantFetch;
    logic        wantLatch;
    logic        wantCall;
    logic        wantStackAddress;
    logic        endOfInstr;

    controlUnit UUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic expectT expectFor(input opcodeT op);
        expectT e;
        case (op)
            opAnd, opAdd, opSub: e = '{4'd7, 2'd2, 1'b0, 1'b0, 1'b0, srcRegister, pcNext};
            opAndi, opAddi:      e = '{4'd7, 2'd2, 1'b0, 1'b0, 1'b0, srcImmediate, pcNext};
            opLw, opLwpoi:       e = '{4'd8, 2'd2, 1'b0, 1'b0, 1'b1, srcImmediate, pcNext};
            opSw:                e = '{4'd6, 2'd0, 1'b0, 1'b0, 1'b0, srcImmediate, pcNext};
            opJmp:               e = '{4'd5, 2'd0, 1'b0, 1'b0, 1'b0, srcJumpOffset, pcJump};
            opCall:              e = '{4'd6, 2'd0, 1'b1, 1'b0, 1'b0, srcJumpOffset, pcJump};
            opRet:               e = '{4'd3, 2'd0, 1'b0, 1'b1, 1'b0, srcRegister, pcNext};
            opPush:              e = '{4'd4, 2'd0, 1'b1, 1'b0, 1'b0, srcRegister, pcNext};
            opPop:               e = '{4'd6, 2'd2, 1'b0, 1'b1, 1'b0, srcRegister, pcJump};
            default:             e = '{4'd5, 2'd0, 1'b0, 1'b0, 1'b0, srcRegister, pcBranch};
        endcase
        return e;
    endfunction

    function automatic logic takenFor(input opcodeT op, input aluFlagsT f);
        return (op == opBgt && f.greater) || (op == opBlt && f.less)
            || (op == opBeq && f.zero) || (op == opBne && !f.zero);
    endfunction

    task automatic logMismatch(input string name, input int expected, input int actual);
        errorCount++;
        $display("ERR %s expected %0d actual %0d", name, expected, actual);
    endtask

    always_comb begin
        want       = expectFor(issuedOp);
        wantTaken  = takenFor(issuedOp, issuedFlags);
        wantMode   = (issuedOp == opLwpoi) && (issuedMode == 2'b01);
        wantFetch  = (sinceFetch == int'(want.cycles));
        // Decode is the second cycle after fetch, read the third where present
        wantLatch  = (issuedOp != opRet) && ((sinceFetch == 2)
            || ((sinceFetch == 3) && !(issuedOp inside {opPush, opPop})));
        wantCall   = (issuedOp == opCall);
        wantStackAddress = (issuedOp == opRet);
        endOfInstr = irWrite && (issuedCount > 0);
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Tallies restart with every fetch
    always @(posedge clk) begin
        if (reset || irWrite) begin
            sinceFetch <= 1;
            rfCount    <= 0;
            pushCount  <= 0;
            popCount   <= 0;
        end else begin
            sinceFetch <= sinceFetch + 1;
            if (rfWrite) begin
                rfCount <= rfCount + 1;
            end
            if (push) begin
                pushCount <= pushCount + 1;
            end
            if (pop) begin
                popCount <= popCount + 1;
            end
        end
    end

    assert property (@(posedge clk)
        $fell(reset) |-> irWrite && !rfWrite && !push && !pop && !branchTaken)
        else begin
            errorCount++;
            $display("Unit not fetching with quiet strobes in the first cycle after reset");
        end

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> sinceFetch == int'(want.cycles))
        else logMismatch("cycleCount", int'($sampled(want.cycles)), $sampled(sinceFetch));

    assert property (@(posedge clk) disable iff (reset)
        issuedCount > 0 |-> pcEnable == wantFetch)
        else logMismatch("pcEnable", int'($sampled(wantFetch)), int'($sampled(pcEnable)));

    assert property (@(posedge clk) disable iff (reset)
        issuedCount > 0 |-> regLatch == wantLatch)
        else logMismatch("regLatch", int'($sampled(wantLatch)), int'($sampled(regLatch)));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> rfCount == int'(want.rfCycles))
        else logMismatch("rfWriteCycles", int'($sampled(want.rfCycles)), $sampled(rfCount));

    assert property (@(posedge clk) disable iff (reset) rfWrite |-> want.rfCycles != 2'd0)
        else logMismatch("rfWriteClass", 0, 1);

    assert property (@(posedge clk) disable iff (reset) $rose(rfWrite) |=> rfWrite)
        else logMismatch("rfWritePair", 1, int'($sampled(rfWrite)));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr && issuedOp inside {opBgt, opBlt, opBeq, opBne, opJmp}
        |-> branchTaken == wantTaken)
        else logMismatch("branchTaken", int'($sampled(wantTaken)), int'($sampled(branchTaken)));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> pushCount == int'(want.pushes))
        else logMismatch("pushCount", int'($sampled(want.pushes)), $sampled(pushCount));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> popCount == int'(want.pops))
        else logMismatch("popCount", int'($sampled(want.pops)), $sampled(popCount));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> callFlag == wantCall)
        else logMismatch("callFlag", int'($sampled(wantCall)), int'($sampled(callFlag)));

    assert property (@(posedge clk) disable iff (reset)
        endOfInstr |-> stackAddress == wantStackAddress)
        else logMismatch("stackAddress", int'($sampled(wantStackAddress)),
            int'($sampled(stackAddress)));

    assert property (@(posedge clk) disable iff (reset)
        rfWrite || endOfInstr |-> ctrl.aluOp == issuedOp[3:0])
        else logMismatch("aluOp", int'($sampled(issuedOp[3:0])), int'($sampled(ctrl.aluOp)));

    assert property (@(posedge clk) disable iff (reset)
        rfWrite || endOfInstr |-> ctrl.aluSrcTwo == want.aluSrcTwo)
        else logMismatch("aluSrcTwo", int'($sampled(want.aluSrcTwo)),
            int'($sampled(ctrl.aluSrcTwo)));

    assert property (@(posedge clk) disable iff (reset)
        rfWrite || endOfInstr |-> ctrl.pcSource == want.pcSource)
        else logMismatch("pcSource", int'($sampled(want.pcSource)),
            int'($sampled(ctrl.pcSource)));

    assert property (@(posedge clk) disable iff (reset)
        rfWrite || endOfInstr |-> ctrl.memRead == want.memRead)
        else logMismatch("memRead", int'($sampled(want.memRead)), int'($sampled(ctrl.memRead)));

    assert property (@(posedge clk) disable iff (reset) endOfInstr |-> modeFlag == wantMode)
        else logMismatch("modeFlag", int'($sampled(wantMode)), int'($sampled(modeFlag)));

    task automatic waitForFetch(output bit fetched);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!irWrite && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        fetched = irWrite;
        if (!fetched) begin
            timeoutCount++;
            $display("Timeout: no instruction fetch seen within %0d cycles", cycles);
        end
    endtask

    // New inputs land on the edge that closes the fetch cycle
    task automatic issueInstruction();
        opcodeT     op;
        logic [1:0] mode;
        aluFlagsT   f;
        rngState = xorshift(rngState);
        op = opcodeT'(6'(rngState % 32'd17));
        rngState = xorshift(rngState);
        mode = rngState[1:0];
        f = aluFlagsT'(rngState[4:2]);
        @(posedge clk);
        opcode      <= op;
        modeBits    <= mode;
        flags       <= f;
        issuedOp    <= op;
        issuedMode  <= mode;
        issuedFlags <= f;
        issuedCount <= issuedCount + 1;
    endtask

    initial begin
        int n;
        bit fetched;
        reset        = 1'b1;
        opcode       = opAnd;
        modeBits     = 2'b00;
        flags        = '0;
        issuedOp     = opAnd;
        issuedMode   = 2'b00;
        issuedFlags  = '0;
        issuedCount  = 0;
        errorCount   = 0;
        timeoutCount = 0;
        rngState     = 32'd38;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        n = 0;
        fetched = 1'b1;
        while (n < numInstr && fetched) begin
            waitForFetch(fetched);
            if (fetched) begin
                issueInstruction();
                n++;
            end
        end
        // Last instruction still has to reach its closing fetch
        if (fetched) begin
            waitForFetch(fetched);
            @(posedge clk);
        end
        @(negedge clk);

        $display("Instructions %0d, errors %0d, timeouts %0d",
            issuedCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== controlUnit.f ====
design/controlPkg.sv
design/instrDecoder.sv
design/phaseSequencer.sv
design/branchResolver.sv
design/stackControl.sv
design/controlUnit.sv
verification/controlUnitTb.sv

// ==== Makefile ====
.PHONY: run clean

run:
	verilator --binary --timing --assert --top-module controlUnitTb -Mdir obj_dir -f controlUnit.f
	./obj_dir/VcontrolUnitTb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
